// ==== filelist.f ====
hdl/sd_timing_pkg.sv
hdl/sd_pixel_pkg.sv
hdl/line_capture.sv
hdl/line_buffer.sv
hdl/line_replay.sv
hdl/scanline_shade.sv
hdl/scandoubler.sv
tb/scandoubler_sva.sv
tb/scandoubler_tb.sv

// ==== hdl/line_buffer.sv ====
// ====================
// two-bank line memory
// one write port and one registered read port
// ====================

`timescale 1ns/1ps

module line_buffer (
	input  logic                                  clk_sys,
	input  logic                                  wr_en,
	input  logic                                  wr_bank,
	input  logic [sd_timing_pkg::HCNT_WIDTH-1:0]  wr_addr,
	input  logic [sd_pixel_pkg::PIXEL_WIDTH-1:0]  wr_pixel,
	input  logic                                  rd_en,
	input  logic [sd_timing_pkg::HCNT_WIDTH-1:0]  rd_addr,
	output logic [sd_pixel_pkg::PIXEL_WIDTH-1:0]  rd_pixel
);
	import sd_timing_pkg::*;
	import sd_pixel_pkg::*;

	logic [PIXEL_WIDTH-1:0]    mem [BUF_DEPTH];
	logic [BUF_ADDR_WIDTH-1:0] wr_ptr;
	logic [BUF_ADDR_WIDTH-1:0] rd_ptr;

	// bank bit on top, pixel index below
	assign wr_ptr = {wr_bank, wr_addr};

	// playback always takes the line that is complete
	assign rd_ptr = {~wr_bank, rd_addr};

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_ptr] <= wr_pixel;
	end

	// read data lands one ce_x2 after the address
	always_ff @(posedge clk_sys) begin
		if (rd_en)
			rd_pixel <= mem[rd_ptr];
	end

endmodule

// ==== hdl/line_capture.sv ====
// ====================
// input side of the scan doubler
// counts native pixels, measures line length and sync position
// and writes each pixel into the bank being filled
// ====================

`timescale 1ns/1ps

module line_capture (
	input  logic                                  clk_sys,
	input  logic                                  rst,
	input  logic                                  ce_x1,
	input  logic                                  hs_in,
	input  logic                                  vs_in,
	input  logic [sd_pixel_pkg::COLOR_DEPTH-1:0]  r_in,
	input  logic [sd_pixel_pkg::COLOR_DEPTH-1:0]  g_in,
	input  logic [sd_pixel_pkg::COLOR_DEPTH-1:0]  b_in,
	output logic                                  wr_en,
	output logic                                  wr_bank,
	output logic [sd_timing_pkg::HCNT_WIDTH-1:0]  wr_addr,
	output logic [sd_pixel_pkg::PIXEL_WIDTH-1:0]  wr_pixel,
	output logic                                  line_start,
	output logic [sd_timing_pkg::HCNT_WIDTH-1:0]  line_len,
	output logic [sd_timing_pkg::HCNT_WIDTH-1:0]  sync_pos
);
	import sd_timing_pkg::*;

	// sync history, one ce_x1 old
	logic hs_d;
	logic vs_d;

	// bank currently being filled
	logic bank;

	// native pixel position within the line
	logic [HCNT_WIDTH-1:0] hcnt;

	// ==================== edge detection

	// falling hsync marks the start of a new input line
	assign line_start = ce_x1 & hs_d & ~hs_in;

	// ==================== counters and line info

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hs_d     <= 1'b0;
			vs_d     <= 1'b0;
			bank     <= 1'b0;
			hcnt     <= '0;
			line_len <= '0;
			sync_pos <= '0;
		end else if (ce_x1) begin
			hs_d <= hs_in;
			vs_d <= vs_in;

			// last index of the finished line becomes the replay wrap point
			if (hs_d && !hs_in) begin
				line_len <= hcnt;
				hcnt     <= '0;
			end else begin
				hcnt <= hcnt + 1'b1;
			end

			// where the sync pulse rises, replayed at double speed
			if (!hs_d && hs_in)
				sync_pos <= hcnt;

			// new frame restarts on bank 0
			if (vs_d != vs_in)
				bank <= 1'b0;

			// swap banks at every line start, wins over the frame reset
			if (hs_d && !hs_in)
				bank <= ~bank;
		end
	end

	// ==================== buffer write port

	// one write per native pixel, same cycle as the enable
	assign wr_en    = ce_x1;
	assign wr_bank  = bank;
	assign wr_addr  = hcnt;
	assign wr_pixel = {r_in, g_in, b_in};

endmodule

// ==== hdl/line_replay.sv ====
// ====================
// output timing at twice the pixel rate
// replays each stored line twice and rebuilds hsync
// ====================

`timescale 1ns/1ps

module line_replay (
	input  logic                                  clk_sys,
	input  logic                                  rst,
	input  logic                                  ce_x2,
	input  logic                                  line_start,
	input  logic [sd_timing_pkg::HCNT_WIDTH-1:0]  line_len,
	input  logic [sd_timing_pkg::HCNT_WIDTH-1:0]  sync_pos,
	output logic                                  rd_en,
	output logic [sd_timing_pkg::HCNT_WIDTH-1:0]  rd_addr,
	output logic                                  hs_dbl
);
	import sd_timing_pkg::*;

	// doubled-rate pixel position
	logic [HCNT_WIDTH-1:0] cnt;

	// set once the input timing has been seen
	logic locked;

	logic at_wrap;

	assign at_wrap = (cnt == line_len);

	// ==================== counter and sync

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cnt    <= '0;
			hs_dbl <= 1'b0;
			locked <= 1'b0;
		end else if (ce_x2) begin
			// park on the wrap value so the next tick opens a half line
			// in phase with the input
			if (line_start) begin
				cnt    <= line_len;
				locked <= 1'b1;
			end else if (at_wrap) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end

			// sync low from the wrap
			if (at_wrap)
				hs_dbl <= 1'b0;

			// rise at the captured position
			// held off until the first line has been measured
			if (locked && cnt == sync_pos)
				hs_dbl <= 1'b1;
		end
	end

	// ==================== buffer read port

	// one read per doubled pixel
	assign rd_en   = ce_x2;
	assign rd_addr = cnt;

endmodule

// ==== hdl/scandoubler.sv ====
// ====================
// scan doubler top level
// capture, line buffer, replay timing and output shading
// ====================

`timescale 1ns/1ps

module scandoubler (
	input  logic                                  clk_sys,
	input  logic                                  rst,
	input  sd_pixel_pkg::scanline_mode_e          scanlines,
	input  logic                                  ce_x1,
	input  logic                                  ce_x2,
	input  logic                                  hs_in,
	input  logic                                  vs_in,
	input  logic [sd_pixel_pkg::COLOR_DEPTH-1:0]  r_in,
	input  logic [sd_pixel_pkg::COLOR_DEPTH-1:0]  g_in,
	input  logic [sd_pixel_pkg::COLOR_DEPTH-1:0]  b_in,
	output logic                                  hs_out,
	output logic                                  vs_out,
	output logic [sd_pixel_pkg::OUT_DEPTH-1:0]    r_out,
	output logic [sd_pixel_pkg::OUT_DEPTH-1:0]    g_out,
	output logic [sd_pixel_pkg::OUT_DEPTH-1:0]    b_out
);
	import sd_timing_pkg::*;
	import sd_pixel_pkg::*;

	// ==================== internal wiring

	// capture to buffer
	logic                   wr_en;
	logic                   wr_bank;
	logic [HCNT_WIDTH-1:0]  wr_addr;
	logic [PIXEL_WIDTH-1:0] wr_pixel;

	// capture to replay
	logic                   line_start;
	logic [HCNT_WIDTH-1:0]  line_len;
	logic [HCNT_WIDTH-1:0]  sync_pos;

	// replay to buffer and output stage
	logic                   rd_en;
	logic [HCNT_WIDTH-1:0]  rd_addr;
	logic [PIXEL_WIDTH-1:0] rd_pixel;
	logic                   hs_dbl;

	// ==================== stages

	line_capture u_capture (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.ce_x1      (ce_x1),
		.hs_in      (hs_in),
		.vs_in      (vs_in),
		.r_in       (r_in),
		.g_in       (g_in),
		.b_in       (b_in),
		.wr_en      (wr_en),
		.wr_bank    (wr_bank),
		.wr_addr    (wr_addr),
		.wr_pixel   (wr_pixel),
		.line_start (line_start),
		.line_len   (line_len),
		.sync_pos   (sync_pos)
	);

	line_buffer u_buffer (
		.clk_sys  (clk_sys),
		.wr_en    (wr_en),
		.wr_bank  (wr_bank),
		.wr_addr  (wr_addr),
		.wr_pixel (wr_pixel),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.rd_pixel (rd_pixel)
	);

	line_replay u_replay (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.ce_x2      (ce_x2),
		.line_start (line_start),
		.line_len   (line_len),
		.sync_pos   (sync_pos),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.hs_dbl     (hs_dbl)
	);

	// vsync bypasses the buffer, no one-line delay
	scanline_shade u_shade (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ce_x2     (ce_x2),
		.scanlines (scanlines),
		.rd_pixel  (rd_pixel),
		.hs_dbl    (hs_dbl),
		.vs_in     (vs_in),
		.hs_out    (hs_out),
		.vs_out    (vs_out),
		.r_out     (r_out),
		.g_out     (g_out),
		.b_out     (b_out)
	);

endmodule

// ==== hdl/scanline_shade.sv ====
// ====================
// output stage
// widens colours, darkens alternate lines, registers all outputs
// ====================

`timescale 1ns/1ps

module scanline_shade (
	input  logic                                  clk_sys,
	input  logic                                  rst,
	input  logic                                  ce_x2,
	input  sd_pixel_pkg::scanline_mode_e          scanlines,
	input  logic [sd_pixel_pkg::PIXEL_WIDTH-1:0]  rd_pixel,
	input  logic                                  hs_dbl,
	input  logic                                  vs_in,
	output logic                                  hs_out,
	output logic                                  vs_out,
	output logic [sd_pixel_pkg::OUT_DEPTH-1:0]    r_out,
	output logic [sd_pixel_pkg::OUT_DEPTH-1:0]    g_out,
	output logic [sd_pixel_pkg::OUT_DEPTH-1:0]    b_out
);
	import sd_pixel_pkg::*;

	// high on the lines that get darkened
	logic parity;

	// mode in effect for the current pixel
	scanline_mode_e mode;

	logic [OUT_DEPTH-1:0] r_wide;
	logic [OUT_DEPTH-1:0] g_wide;
	logic [OUT_DEPTH-1:0] b_wide;

	// ==================== colour helpers

	// repeat the top bits below the channel so white stays full scale
	function automatic logic [OUT_DEPTH-1:0] widen(input logic [COLOR_DEPTH-1:0] c);
		widen = {c, c[COLOR_DEPTH-1 -: EXT_BITS]};
	endfunction

	function automatic logic [OUT_DEPTH-1:0] dim(
		input logic [OUT_DEPTH-1:0] c,
		input scanline_mode_e       m
	);
		logic [OUT_DEPTH-1:0] half;
		logic [OUT_DEPTH-1:0] quarter;
		half    = c >> 1;
		quarter = c >> 2;
		case (m)
			// 3/4 of the level, never overflows
			sl_dim25: dim = half + quarter;
			sl_dim50: dim = half;
			sl_dim75: dim = quarter;
			default:  dim = c;
		endcase
	endfunction

	// unpack red, green, blue from the top down
	assign r_wide = widen(rd_pixel[3*COLOR_DEPTH-1 -: COLOR_DEPTH]);
	assign g_wide = widen(rd_pixel[2*COLOR_DEPTH-1 -: COLOR_DEPTH]);
	assign b_wide = widen(rd_pixel[COLOR_DEPTH-1:0]);

	// even lines pass straight through
	assign mode = parity ? scanlines : sl_none;

	// ==================== output registers

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hs_out <= 1'b0;
			vs_out <= 1'b0;
			r_out  <= '0;
			g_out  <= '0;
			b_out  <= '0;
			parity <= 1'b0;
		end else if (ce_x2) begin
			hs_out <= hs_dbl;
			vs_out <= vs_in;

			// restart the pattern on a new frame
			if (vs_out != vs_in)
				parity <= 1'b0;

			// next output line begins at the hsync fall
			if (hs_out && !hs_dbl)
				parity <= ~parity;

			r_out <= dim(r_wide, mode);
			g_out <= dim(g_wide, mode);
			b_out <= dim(b_wide, mode);
		end
	end

endmodule

// ==== hdl/sd_pixel_pkg.sv ====
// ====================
// pixel format constants and the scanline mode type
// ====================

package sd_pixel_pkg;

	// ==================== colour depth

	// bits per channel at the core input
	localparam int COLOR_DEPTH = 4;

	// packed pixel in the line buffer, red in the top bits then green then blue
	localparam int PIXEL_WIDTH = 3 * COLOR_DEPTH;

	// bits per channel at the video output
	localparam int OUT_DEPTH = 6;

	// low bits filled in by repeating the top of the channel
	localparam int EXT_BITS = OUT_DEPTH - COLOR_DEPTH;

	// ==================== scanline effect

	// strength of the darkening on every other output line
	typedef enum logic [1:0] {
		sl_none  = 2'd0,
		sl_dim25 = 2'd1,
		sl_dim50 = 2'd2,
		sl_dim75 = 2'd3
	} scanline_mode_e;

endpackage

// ==== hdl/sd_timing_pkg.sv ====
// ====================
// line timing constants for the scan doubler
// horizontal counter width and line buffer geometry
// ====================

package sd_timing_pkg;

	// ==================== horizontal counters

	// width of both the input and the doubled-rate pixel counters
	// 9 bits covers lines of up to 512 native pixels
	localparam int HCNT_WIDTH = 9;

	// ==================== line buffer

	// one bank bit on top of the pixel index
	localparam int BUF_ADDR_WIDTH = HCNT_WIDTH + 1;

	// two banks of 2**HCNT_WIDTH pixels each
	localparam int BUF_DEPTH = 2 ** BUF_ADDR_WIDTH;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the scan doubler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module scandoubler_tb \
	-f filelist.f \
	--Mdir obj_dir -o scandoubler_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/scandoubler_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1

// ==== tb/scandoubler_sva.sv ====
// ====================
// concurrent checks on the scan doubler top level
// sync hold-off, output enable discipline, vsync delay
// ====================

`timescale 1ns/1ps

module scandoubler_sva (
	input logic                                clk_sys,
	input logic                                rst,
	input logic                                ce_x2,
	input logic                                line_start,
	input logic                                hs_out,
	input logic                                vs_in,
	input logic                                vs_out,
	input logic [sd_pixel_pkg::OUT_DEPTH-1:0]  r_out,
	input logic [sd_pixel_pkg::OUT_DEPTH-1:0]  g_out,
	input logic [sd_pixel_pkg::OUT_DEPTH-1:0]  b_out
);

	// set by the first measured input line
	logic seen_start;

	always_ff @(posedge clk_sys) begin
		if (rst)
			seen_start <= 1'b0;
		else if (line_start)
			seen_start <= 1'b1;
	end

	// no output sync until input timing is known
	hs_quiet_before_start: assert property (@(posedge clk_sys) disable iff (rst)
		!seen_start |-> !hs_out)
		else $error("hs_out high before the first line start");

	// colours only move on doubled-rate enables
	colour_on_ce_x2: assert property (@(posedge clk_sys) disable iff (rst)
		!ce_x2 |=> $stable({r_out, g_out, b_out}))
		else $error("colour output changed without ce_x2");

	// vsync is a one-tick pass through
	vs_one_tick: assert property (@(posedge clk_sys) disable iff (rst)
		ce_x2 |=> (vs_out == $past(vs_in)))
		else $error("vs_out does not follow vs_in");

endmodule

bind scandoubler scandoubler_sva u_sva (
	.clk_sys    (clk_sys),
	.rst        (rst),
	.ce_x2      (ce_x2),
	.line_start (line_start),
	.hs_out     (hs_out),
	.vs_in      (vs_in),
	.vs_out     (vs_out),
	.r_out      (r_out),
	.g_out      (g_out),
	.b_out      (b_out)
);

// ==== tb/scandoubler_tb.sv ====
// ====================
// testbench for the scan doubler
// enables and video line generator, reference model
// sync, colour, dimming and frame parity checks
// ====================

`timescale 1ns/1ps

module scandoubler_tb;
	import sd_pixel_pkg::*;

	// ==================== generated video timing

	localparam int LINE_PIXELS = 64;
	localparam int SYNC_PIXELS = 8;

	// four clk_sys cycles per native pixel
	localparam int LINE_CLKS = 4 * LINE_PIXELS;

	// half of one doubled line is 32 ce_x2 ticks
	localparam int HALF_OUT_CLKS = LINE_CLKS / 4;

	logic                   clk_sys;
	logic                   rst;
	scanline_mode_e         scanlines;
	logic                   ce_x1;
	logic                   ce_x2;
	logic                   hs_in;
	logic                   vs_in;
	logic [COLOR_DEPTH-1:0] r_in;
	logic [COLOR_DEPTH-1:0] g_in;
	logic [COLOR_DEPTH-1:0] b_in;
	logic                   hs_out;
	logic                   vs_out;
	logic [OUT_DEPTH-1:0]   r_out;
	logic [OUT_DEPTH-1:0]   g_out;
	logic [OUT_DEPTH-1:0]   b_out;

	// generator state
	logic [1:0]             phase;
	int                     cyc;
	int                     px;
	logic [PIXEL_WIDTH-1:0] line_colour;

	// one solid colour per input line indexed by line number
	logic [PIXEL_WIDTH-1:0] colour_q [$];
	int                     line_idx;

	// vsync toggle requests are served at the next line start
	int                     vs_requests;
	int                     vs_served;

	int                     tests_run;
	int                     tests_failed;

	scandoubler uut (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.scanlines (scanlines),
		.ce_x1     (ce_x1),
		.ce_x2     (ce_x2),
		.hs_in     (hs_in),
		.vs_in     (vs_in),
		.r_in      (r_in),
		.g_in      (g_in),
		.b_in      (b_in),
		.hs_out    (hs_out),
		.vs_out    (vs_out),
		.r_out     (r_out),
		.g_out     (g_out),
		.b_out     (b_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ==================== stimulus

	// one native pixel with sync high over the last SYNC_PIXELS
	task automatic next_pixel();
		if (px == 0) begin
			line_colour = PIXEL_WIDTH'($urandom % 4095 + 1);
			colour_q.push_back(line_colour);
			line_idx = colour_q.size() - 1;
			// frame edge lands on a line start
			if (vs_served != vs_requests) begin
				vs_in = ~vs_in;
				vs_served = vs_requests;
			end
		end
		hs_in = (px >= LINE_PIXELS - SYNC_PIXELS);
		{r_in, g_in, b_in} = line_colour;
		px = (px + 1) % LINE_PIXELS;
	endtask

	// reset, enables and pixels all move 2 ns after the rising edge
	initial begin : stimulus
		void'($urandom(89324));
		rst = 1'b1;
		ce_x1 = 1'b0;
		ce_x2 = 1'b0;
		hs_in = 1'b0;
		vs_in = 1'b0;
		r_in = '0;
		g_in = '0;
		b_in = '0;
		phase = 2'd0;
		cyc = 0;
		px = 0;
		line_idx = -1;
		vs_served = 0;
		forever begin
			@(posedge clk_sys);
			#2;
			cyc++;
			if (cyc == 4)
				rst = 1'b0;
			// ce_x2 every second cycle, ce_x1 on every second ce_x2
			phase = phase + 2'd1;
			ce_x2 = phase[0];
			ce_x1 = (phase == 2'd3);
			if (ce_x1 && !rst)
				next_pixel();
		end
	end

	// ==================== reference model

	// 6-bit channels packed r, g, b from the top
	function automatic logic [3*OUT_DEPTH-1:0] expected_pixel(
		input logic [PIXEL_WIDTH-1:0] colour,
		input scanline_mode_e         mode,
		input logic                   parity
	);
		logic [3*OUT_DEPTH-1:0] res;
		int ch;
		int c;
		int w;
		res = '0;
		for (ch = 0; ch < 3; ch++) begin
			c = int'(colour[ch*COLOR_DEPTH +: COLOR_DEPTH]);
			// level n on 4 bits is n*4 + n/4 on 6 bits
			w = c * 4 + c / 4;
			if (parity && mode != sl_none) begin
				case (mode)
					sl_dim25: w = w / 2 + w / 4;
					sl_dim50: w = w / 2;
					default:  w = w / 4;
				endcase
			end
			res[ch*OUT_DEPTH +: OUT_DEPTH] = OUT_DEPTH'(w);
		end
		return res;
	endfunction

	// ==================== helpers

	task automatic give_up(input string what);
		$display("timeout: %s", what);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic finish_test(input string name, input logic ok);
		tests_run++;
		if (!ok)
			tests_failed++;
		$display("test %s: %s", name, ok ? "ok" : "FAILED");
	endtask

	task automatic set_mode(input scanline_mode_e mode);
		@(posedge clk_sys);
		#2;
		scanlines = mode;
		@(negedge clk_sys);
	endtask

	task automatic wait_reset_release();
		int n;
		for (n = 0; n < 16; n++) begin
			@(negedge clk_sys);
			if (!rst)
				return;
		end
		give_up("reset was not released");
	endtask

	// a few lines so line_len and sync_pos are measured
	task automatic wait_lines_measured();
		int n;
		for (n = 0; n < 8 * LINE_CLKS; n++) begin
			@(negedge clk_sys);
			if (line_idx >= 3)
				return;
		end
		give_up("video generator did not start");
	endtask

	task automatic wait_new_line();
		int start;
		int n;
		start = line_idx;
		for (n = 0; n < 2 * LINE_CLKS; n++) begin
			@(negedge clk_sys);
			if (line_idx != start)
				return;
		end
		give_up("no new input line");
	endtask

	// falling hs_out opens an output line
	task automatic wait_hs_fall();
		logic prev;
		int n;
		prev = hs_out;
		for (n = 0; n < 2 * LINE_CLKS; n++) begin
			@(negedge clk_sys);
			if (prev && !hs_out)
				return;
			prev = hs_out;
		end
		give_up("no falling edge on hs_out");
	endtask

	// middle of the next output line far from both edges
	task automatic sample_mid(output logic [3*OUT_DEPTH-1:0] got);
		wait_hs_fall();
		repeat (HALF_OUT_CLKS) @(negedge clk_sys);
		got = {r_out, g_out, b_out};
	endtask

	// ==================== checks

	// two hs_out pulses per input line each 8 ce_x2 ticks high
	task automatic check_sync(input string name);
		int start;
		int n;
		int rises;
		int high_clks;
		logic prev;
		logic in_pulse;
		logic ok;
		ok = 1'b1;
		rises = 0;
		high_clks = 0;
		in_pulse = 1'b0;
		wait_new_line();
		start = line_idx;
		prev = hs_out;
		// the last pulse of the line is followed into the next one
		for (n = 0; n < 2 * LINE_CLKS && (line_idx == start || in_pulse); n++) begin
			@(negedge clk_sys);
			if (!prev && hs_out && line_idx == start) begin
				rises++;
				in_pulse = 1'b1;
				high_clks = 0;
			end
			if (in_pulse && hs_out)
				high_clks++;
			// pulses that began before the window are skipped
			if (in_pulse && prev && !hs_out) begin
				in_pulse = 1'b0;
				assert (high_clks / 2 >= 7 && high_clks / 2 <= 9) else begin
					$display("CHECK FAILED %s: expected 8 ticks high actual %0d",
						name, high_clks / 2);
					ok = 1'b0;
				end
			end
			prev = hs_out;
		end
		if (line_idx == start || in_pulse) begin
			give_up("input line or hs_out pulse did not end");
		end else begin
			assert (rises == 2) else begin
				$display("CHECK FAILED %s: expected 2 rises actual %0d", name, rises);
				ok = 1'b0;
			end
			finish_test(name, ok);
		end
	endtask

	task automatic check_pair(input string name, input scanline_mode_e mode);
		logic [3*OUT_DEPTH-1:0] first;
		logic [3*OUT_DEPTH-1:0] second;
		logic [3*OUT_DEPTH-1:0] plain;
		logic [3*OUT_DEPTH-1:0] dark;
		logic ok;
		ok = 1'b1;
		set_mode(mode);
		wait_new_line();
		// the pair replays the line before the current one
		plain = expected_pixel(colour_q[line_idx - 1], mode, 1'b0);
		dark = expected_pixel(colour_q[line_idx - 1], mode, 1'b1);
		sample_mid(first);
		sample_mid(second);
		if (mode == sl_none) begin
			assert (first == plain && second == plain) else begin
				$display("CHECK FAILED %s: expected %h %h actual %h %h",
					name, plain, plain, first, second);
				ok = 1'b0;
			end
		end else begin
			assert (first != second &&
				((first == plain && second == dark) ||
				(first == dark && second == plain))) else begin
				$display("CHECK FAILED %s: expected %h and %h in any order actual %h %h",
					name, plain, dark, first, second);
				ok = 1'b0;
			end
		end
		finish_test(name, ok);
	endtask

	// on a new frame the first line is dimmed and the second plain
	task automatic check_vsync_parity(input string name);
		logic [3*OUT_DEPTH-1:0] first;
		logic [3*OUT_DEPTH-1:0] second;
		logic [3*OUT_DEPTH-1:0] plain;
		logic [3*OUT_DEPTH-1:0] dark;
		logic ok;
		ok = 1'b1;
		set_mode(sl_dim50);
		vs_requests++;
		wait_new_line();
		plain = expected_pixel(colour_q[line_idx - 1], sl_dim50, 1'b0);
		dark = expected_pixel(colour_q[line_idx - 1], sl_dim50, 1'b1);
		sample_mid(first);
		sample_mid(second);
		assert (first == dark && second == plain) else begin
			$display("CHECK FAILED %s: expected %h %h actual %h %h",
				name, dark, plain, first, second);
			ok = 1'b0;
		end
		finish_test(name, ok);
	endtask

	// ==================== test sequence

	initial begin : main
		logic [3*OUT_DEPTH+1:0] after_rst;
		logic ok;
		scanlines = sl_none;
		vs_requests = 0;
		tests_run = 0;
		tests_failed = 0;

		// outputs on the first edge after the reset release
		wait_reset_release();
		@(negedge clk_sys);
		after_rst = {hs_out, vs_out, r_out, g_out, b_out};
		ok = 1'b1;
		assert (after_rst == '0) else begin
			$display("CHECK FAILED reset: expected %h actual %h", 20'h0, after_rst);
			ok = 1'b0;
		end
		finish_test("reset", ok);

		wait_lines_measured();

		check_sync("sync_doubling");
		check_pair("pass_through", sl_none);
		check_pair("dim25", sl_dim25);
		check_pair("dim50", sl_dim50);
		check_pair("dim75", sl_dim75);
		check_vsync_parity("vsync_parity");

		$display("tests run %0d, passed %0d, failed %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
